// File: bench/br_unit_checker.sv
`timescale 1ns/100ps

module br_unit_checker (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               check_en,       // vector applied this cycle
    input  int                 test_id,
    input  br_pkg::redirect_t  exp_redirect,
    input  br_pkg::bp_update_t exp_update,
    input  br_pkg::redirect_t  redirect,       // dut outputs
    input  br_pkg::bp_update_t bp_update,
    input  logic               finish,         // stimulus exhausted
    output int                 err_cnt,
    output logic               summary_done
);

    int   cur_test = 0;
    int   test_vec = 0;                        // vectors in current test
    int   test_err = 0;
    int   vec_cnt = 0;
    int   test_cnt = 0;
    int   err_total = 0;
    logic summary_flag = 1'b0;

    assign err_cnt      = err_total;
    assign summary_done = summary_flag;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail test %0d vector %0d: %s got %h expected %h",
                     cur_test, test_vec, name, got, exp);
            test_err++;
            err_total++;
        end
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            $display("test %0d: %0d vectors, %0d errors", cur_test, test_vec, test_err);
            test_cnt++;
        end
    endtask

    // falling edge, outputs settled since the drive
    always @(negedge clk) begin
        if (rst_n && check_en) begin
            if (test_id != cur_test) begin
                close_test();                  // previous test finished
                cur_test = test_id;
                test_vec = 0;
                test_err = 0;
            end
            test_vec++;
            vec_cnt++;
            compare_field("redirect.valid", 32'(redirect.valid), 32'(exp_redirect.valid));
            if (exp_redirect.valid) begin      // target only meaningful when valid
                compare_field("redirect.from_a", 32'(redirect.from_a),
                              32'(exp_redirect.from_a));
                compare_field("redirect.target", redirect.target, exp_redirect.target);
            end
            compare_field("bp_update.valid", 32'(bp_update.valid), 32'(exp_update.valid));
            if (exp_update.valid) begin
                compare_field("bp_update.pc", bp_update.pc, exp_update.pc);
                compare_field("bp_update.pd_type", 32'(bp_update.pd_type),
                              32'(exp_update.pd_type));
                compare_field("bp_update.target", bp_update.target, exp_update.target);
                compare_field("bp_update.taken", 32'(bp_update.taken), 32'(exp_update.taken));
            end
        end else if (finish && !summary_flag) begin
            close_test();                      // last test
            $display("summary: %0d tests, %0d vectors, %0d errors",
                     test_cnt, vec_cnt, err_total);
            summary_flag = 1'b1;
        end
    end

endmodule

// File: bench/br_unit_golden.txt
# test | slot a: pc rj rd imm type pdt pdty | slot b: same | smem sdiv cred
# exp redirect: valid from_a target | exp update: valid pc pdty target taken
1 1000 5 5 40 1 0 1  0 0 0 0 0 0 0  0 0 1  1 1 1040  1 1000 1 1040 1
1 1010 5 6 40 1 1 1  0 0 0 0 0 0 0  0 0 1  1 1 1014  1 1010 1 1050 0
1 1020 5 6 40 2 0 1  0 0 0 0 0 0 0  0 0 1  1 1 1060  1 1020 1 1060 1
1 1030 5 5 40 2 1 1  0 0 0 0 0 0 0  0 0 1  1 1 1034  1 1030 1 1070 0
1 1040 ffffffff 1 40 3 0 1  0 0 0 0 0 0 0  0 0 1  1 1 1080  1 1040 1 1080 1
1 1050 1 ffffffff 40 3 1 1  0 0 0 0 0 0 0  0 0 1  1 1 1054  1 1050 1 1090 0
1 1060 1 ffffffff 40 4 0 1  0 0 0 0 0 0 0  0 0 1  1 1 10a0  1 1060 1 10a0 1
1 1070 ffffffff 1 40 4 1 1  0 0 0 0 0 0 0  0 0 1  1 1 1074  1 1070 1 10b0 0
1 1080 1 ffffffff 40 5 0 1  0 0 0 0 0 0 0  0 0 1  1 1 10c0  1 1080 1 10c0 1
1 1090 ffffffff 1 40 5 1 1  0 0 0 0 0 0 0  0 0 1  1 1 1094  1 1090 1 10d0 0
1 10a0 ffffffff 1 40 6 0 1  0 0 0 0 0 0 0  0 0 1  1 1 10e0  1 10a0 1 10e0 1
1 10b0 1 ffffffff 40 6 1 1  0 0 0 0 0 0 0  0 0 1  1 1 10b4  1 10b0 1 10f0 0
2 2000 0 0 100 7 1 1  0 0 0 0 0 0 0  0 0 1  0 0 0  1 2000 1 2100 1
2 2010 0 0 fffffff0 8 1 2  0 0 0 0 0 0 0  0 0 1  0 0 0  1 2010 2 2000 1
2 2020 3000 0 8 9 1 3  0 0 0 0 0 0 0  0 0 1  0 0 0  1 2020 3 3008 1
3 3000 1 1 20 1 0 1  3004 1 1 40 2 1 1  0 0 1  1 1 3020  1 3000 1 3020 1
3 3010 1 2 20 1 0 0  3014 ffffffff 0 30 3 0 1  0 0 1  1 0 3044  1 3014 1 3044 1
3 3020 1 2 10 2 1 1  3024 0 1 50 6 1 1  0 0 1  1 0 3028  1 3020 1 3030 1
3 3030 0 0 10 7 1 0  0 0 0 0 0 0 0  0 0 1  0 0 0  0 0 0 0 0
4 4000 7 7 80 1 0 1  0 0 0 0 0 0 0  1 0 1  1 1 4080  1 4000 1 4080 1
4 4000 7 7 80 1 0 1  0 0 0 0 0 0 0  1 0 1  0 0 0  0 0 0 0 0
4 4000 7 7 80 1 0 1  0 0 0 0 0 0 0  1 0 1  0 0 0  0 0 0 0 0
4 4000 7 7 80 1 0 1  0 0 0 0 0 0 0  0 0 1  0 0 0  0 0 0 0 0
4 4000 7 7 80 1 0 1  0 0 0 0 0 0 0  0 0 1  0 0 0  0 0 0 0 0
4 4000 7 7 80 1 0 1  0 0 0 0 0 0 0  0 0 1  1 1 4080  1 4000 1 4080 1
4 4100 1 2 80 2 0 1  0 0 0 0 0 0 0  0 1 1  1 1 4180  1 4100 1 4180 1
4 4100 1 2 80 2 0 1  0 0 0 0 0 0 0  0 1 1  0 0 0  0 0 0 0 0
4 4100 1 2 80 2 0 1  0 0 0 0 0 0 0  0 1 1  0 0 0  0 0 0 0 0
4 4100 1 2 80 2 0 1  0 0 0 0 0 0 0  0 0 1  0 0 0  0 0 0 0 0
4 4100 1 2 80 2 0 1  0 0 0 0 0 0 0  0 0 1  0 0 0  0 0 0 0 0
4 4100 1 2 80 2 0 1  0 0 0 0 0 0 0  0 0 1  1 1 4180  1 4100 1 4180 1
5 0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 1  0 0 0  0 0 0 0 0
5 5000 0 0 100 1 0 1  0 0 0 0 0 0 0  0 0 0  1 1 5100  1 5000 1 5100 1
5 5010 0 0 100 1 0 1  0 0 0 0 0 0 0  0 0 0  1 1 5110  1 5010 1 5110 1
5 5020 0 0 100 1 0 1  0 0 0 0 0 0 0  0 0 0  1 1 5120  1 5020 1 5120 1
5 5030 0 0 100 1 0 1  0 0 0 0 0 0 0  0 0 0  1 1 5130  1 5030 1 5130 1
5 5040 0 0 100 1 0 1  0 0 0 0 0 0 0  0 0 0  1 1 5140  0 0 0 0 0
5 0 0 0 0 0 0 0  0 0 0 0 0 0 0  0 0 1  0 0 0  0 0 0 0 0
5 5060 0 0 100 1 0 1  0 0 0 0 0 0 0  0 0 0  1 1 5160  1 5060 1 5160 1

// File: bench/br_unit_props.sv
`timescale 1ns/100ps
`include "br_params.svh"

module br_unit_props (
    input logic                 clk,
    input logic                 rst_n,
    input logic                 redirect_valid,
    input logic                 update_valid,
    input logic                 stall_mem,
    input logic                 stall_div,
    input logic                 credit_ret,    // credit return pulse
    input logic [`CREDIT_W-1:0] credit_cnt
);

    // every sent update takes one credit, none when the count is empty
    upd_uses_credit: assert property (@(posedge clk) disable iff (!rst_n)
        (update_valid && !credit_ret) |=> (credit_cnt == $past(credit_cnt) - 1'b1))
        else $error("update sent without taking a credit");

    // stalled branch redirects once, guard blocks the next cycle
    no_repeat_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        (redirect_valid && (stall_mem || stall_div)) |=> !redirect_valid)
        else $error("redirect repeated while the branch was stalled");

    credit_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        credit_cnt <= `CREDIT_W'(`UPD_CREDITS))
        else $error("credit count above the channel depth");

endmodule

bind br_unit_top br_unit_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .redirect_valid (redirect.valid),
    .update_valid   (bp_update.valid),
    .stall_mem      (stall_mem),
    .stall_div      (stall_div),
    .credit_ret     (upd_credit),
    .credit_cnt     (u_credit.credit_cnt)
);

// File: bench/br_unit_tb.sv
`timescale 1ns/100ps

module br_unit_tb;

    localparam int CLK_HALF  = 50;             // 100 ns period
    localparam int DRIVE_DLY = 10;             // after the rising edge
    localparam int MAX_LINES = 1000;           // bound on the read loop
    localparam int FIELDS    = 26;
    localparam int END_WAIT  = 20;             // cycles for the summary

    logic               clk = 1'b0;
    logic               rst_n;
    br_pkg::br_slot_t   slot_a;
    br_pkg::br_slot_t   slot_b;
    logic               stall_mem;
    logic               stall_div;
    logic               upd_credit;
    br_pkg::redirect_t  redirect;
    br_pkg::bp_update_t bp_update;

    logic               check_en;
    logic               finish;
    int                 test_id;
    br_pkg::redirect_t  exp_redirect;
    br_pkg::bp_update_t exp_update;
    int                 err_cnt;
    logic               summary_done;

    int                 fd;
    int                 n_chr;
    int                 n_fld;
    int                 line_cnt;
    int                 bad_lines;             // unreadable or missing input
    int                 wait_cnt;
    string              line;
    logic [31:0]        fld [FIELDS];

    br_unit_top dut_i (.*);

    br_unit_checker chk_i (.*);

    always #CLK_HALF clk = ~clk;

    task automatic clear_inputs();
        slot_a       = '0;
        slot_b       = '0;
        stall_mem    = 1'b0;
        stall_div    = 1'b0;
        upd_credit   = 1'b0;
        check_en     = 1'b0;
        test_id      = 0;
        exp_redirect = '0;
        exp_update   = '0;
    endtask

    // field order follows the struct layouts
    task automatic apply_vector();
        test_id      = int'(fld[0]);
        slot_a       = {fld[1], fld[2], fld[3], fld[4], fld[5][3:0], fld[6][0], fld[7][1:0]};
        slot_b       = {fld[8], fld[9], fld[10], fld[11], fld[12][3:0], fld[13][0],
                        fld[14][1:0]};
        stall_mem    = fld[15][0];
        stall_div    = fld[16][0];
        upd_credit   = fld[17][0];             // one credit back this cycle
        exp_redirect = {fld[18][0], fld[19][0], fld[20]};
        exp_update   = {fld[21][0], fld[22], fld[23][1:0], fld[24], fld[25][0]};
        check_en     = 1'b1;
    endtask

    initial begin
        rst_n     = 1'b0;
        finish    = 1'b0;
        bad_lines = 0;
        line_cnt  = 0;
        clear_inputs();
        fd = $fopen("bench/br_unit_golden.txt", "r");
        if (fd == 0) begin
            $display("could not open the golden vector file");
            bad_lines++;
        end
        repeat (2) @(posedge clk);             // reset held two cycles
        #DRIVE_DLY;
        rst_n = 1'b1;
        while (fd != 0 && !$feof(fd) && line_cnt < MAX_LINES) begin
            line_cnt++;
            n_chr = $fgets(line, fd);
            if (n_chr > 1 && line.getc(0) != "#") begin
                n_fld = $sscanf(line,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                    fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                    fld[15], fld[16], fld[17], fld[18], fld[19], fld[20],
                    fld[21], fld[22], fld[23], fld[24], fld[25]);
                if (n_fld == FIELDS) begin
                    apply_vector();
                    @(posedge clk);            // checker samples mid cycle
                    #DRIVE_DLY;
                end else begin
                    $display("vector line %0d could not be read", line_cnt);
                    bad_lines++;
                end
            end
        end
        if (fd != 0 && !$feof(fd)) begin
            $display("read loop gave up before the end of the golden file");
            bad_lines++;
        end
        clear_inputs();
        finish   = 1'b1;
        wait_cnt = 0;
        while (!summary_done && wait_cnt < END_WAIT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (!summary_done) begin
            $display("checker summary did not arrive in time");
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        if (summary_done && err_cnt == 0 && bad_lines == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
+incdir+include
source/br_pkg.sv
source/branch_eval.sv
source/br_resolve.sv
source/stall_guard_fsm.sv
source/upd_credit_counter.sv
source/br_unit_top.sv
bench/br_unit_checker.sv
bench/br_unit_props.sv
bench/br_unit_tb.sv

// File: include/br_params.svh
`ifndef BR_PARAMS_SVH
`define BR_PARAMS_SVH

// branch decode codes, as they leave the decoder
`define BR_NONE     4'd0        // not a branch
`define BR_BEQ      4'd1
`define BR_BNE      4'd2
`define BR_BLT      4'd3        // signed
`define BR_BGE      4'd4        // signed
`define BR_BLTU     4'd5
`define BR_BGEU     4'd6
`define BR_B        4'd7        // unconditional, pc relative
`define BR_BL       4'd8        // call, pc relative
`define BR_JIRL     4'd9        // register indirect

// predictor class codes
`define PD_NONE     2'd0
`define PD_COND     2'd1
`define PD_CALL     2'd2
`define PD_RET      2'd3        // return or other indirect

`define UPD_CREDITS 4           // depth of the predictor update queue
`define CREDIT_W    3           // wide enough to hold UPD_CREDITS
`define INSN_BYTES  4           // fixed length encoding

`endif

// File: run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module br_unit_tb -o sim_br_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/sim_br_unit)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "test passed"; then
    exit 0
fi
exit 1

// File: source/br_pkg.sv
package br_pkg;

    typedef logic [31:0] pc_t;      // instruction address
    typedef logic [31:0] word_t;    // operand or immediate
    typedef logic [3:0]  br_type_t; // decode branch code
    typedef logic [1:0]  pd_type_t; // predictor class

    // one execute slot as seen by the branch unit
    typedef struct packed {
        pc_t      pc;
        word_t    rj;               // first source operand
        word_t    rd;               // second source operand
        word_t    imm;              // sign extended offset
        br_type_t br_type;
        logic     pd_taken;         // front end guessed taken
        pd_type_t pd_type;
    } br_slot_t;

    typedef struct packed {
        logic valid;
        logic from_a;               // fix came from the older slot
        pc_t  target;               // where fetch restarts
    } redirect_t;

    typedef struct packed {
        logic     valid;
        pc_t      pc;               // pc of the trained branch
        pd_type_t pd_type;
        pc_t      target;           // computed target, not the fix target
        logic     taken;            // actual direction
    } bp_update_t;

    typedef enum logic [1:0] {
        IDLE,                       // redirects pass
        HOLD,                       // stalled after a redirect
        RELEASE                     // first cycle after the stall
    } guard_state_t;

endpackage

// File: source/br_resolve.sv
`timescale 1ns/100ps
`include "br_params.svh"

module br_resolve (
    input  br_pkg::br_slot_t   slot_a,
    input  br_pkg::br_slot_t   slot_b,
    input  logic               taken_a,
    input  logic               taken_b,
    input  br_pkg::pc_t        target_a,
    input  br_pkg::pc_t        target_b,
    input  logic               suppress,     // stall guard active
    input  logic               credit_ok,    // update channel has room
    output br_pkg::redirect_t  raw_redirect, // before the stall guard
    output br_pkg::redirect_t  redirect,
    output br_pkg::bp_update_t bp_update,
    output logic               consume       // update sent this cycle
);

    logic               fix_a;               // slot a mispredicted
    logic               fix_b;
    br_pkg::pc_t        fix_tgt_a;           // restart address for slot a
    br_pkg::pc_t        fix_tgt_b;
    logic               upd_from_a;          // slot a trains the predictor
    logic               has_pd_b;
    br_pkg::bp_update_t raw_update;

    // mispredict when the guessed direction is wrong
    assign fix_a = (slot_a.br_type != `BR_NONE) & (slot_a.pd_taken ^ taken_a);
    assign fix_b = (slot_b.br_type != `BR_NONE) & (slot_b.pd_taken ^ taken_b);

    // taken goes to the target, not taken falls through
    assign fix_tgt_a = taken_a ? target_a : slot_a.pc + 32'(`INSN_BYTES);
    assign fix_tgt_b = taken_b ? target_b : slot_b.pc + 32'(`INSN_BYTES);

    // older slot wins
    always_comb begin
        raw_redirect.valid  = fix_a | fix_b;
        raw_redirect.from_a = fix_a;
        raw_redirect.target = fix_a ? fix_tgt_a : fix_tgt_b;
    end

    assign upd_from_a = (slot_a.pd_type != `PD_NONE);
    assign has_pd_b   = (slot_b.pd_type != `PD_NONE);

    // a predicted branch in slot a trains, else slot b if it has one
    always_comb begin
        raw_update.valid   = upd_from_a | has_pd_b;
        raw_update.pc      = upd_from_a ? slot_a.pc       : slot_b.pc;
        raw_update.pd_type = upd_from_a ? slot_a.pd_type  : slot_b.pd_type;
        raw_update.target  = upd_from_a ? target_a        : target_b;
        raw_update.taken   = upd_from_a ? taken_a         : taken_b;
    end

    // guard blocks repeats; stalls alone do not gate here
    always_comb begin
        redirect       = raw_redirect;
        redirect.valid = raw_redirect.valid & ~suppress;
    end

    // training is a hint, dropped when no credit
    assign consume = raw_update.valid & ~suppress & credit_ok;

    always_comb begin
        bp_update       = raw_update;
        bp_update.valid = consume;
    end

endmodule

// File: source/br_unit_top.sv
`timescale 1ns/100ps

module br_unit_top (
    input  logic               clk,
    input  logic               rst_n,
    input  br_pkg::br_slot_t   slot_a,       // older slot
    input  br_pkg::br_slot_t   slot_b,
    input  logic               stall_mem,
    input  logic               stall_div,
    input  logic               upd_credit,   // credit return pulse
    output br_pkg::redirect_t  redirect,
    output br_pkg::bp_update_t bp_update
);

    logic              taken_a;
    logic              taken_b;
    br_pkg::pc_t       target_a;
    br_pkg::pc_t       target_b;
    br_pkg::redirect_t raw_redirect;
    logic              suppress;
    logic              credit_ok;
    logic              consume;

    branch_eval u_eval_a (
        .slot   (slot_a),
        .taken  (taken_a),
        .target (target_a)
    );

    branch_eval u_eval_b (
        .slot   (slot_b),
        .taken  (taken_b),
        .target (target_b)
    );

    br_resolve u_resolve (
        .slot_a       (slot_a),
        .slot_b       (slot_b),
        .taken_a      (taken_a),
        .taken_b      (taken_b),
        .target_a     (target_a),
        .target_b     (target_b),
        .suppress     (suppress),
        .credit_ok    (credit_ok),
        .raw_redirect (raw_redirect),
        .redirect     (redirect),
        .bp_update    (bp_update),
        .consume      (consume)
    );

    stall_guard_fsm u_guard (
        .clk       (clk),
        .rst_n     (rst_n),
        .raw_br    (raw_redirect.valid),
        .stall_mem (stall_mem),
        .stall_div (stall_div),
        .suppress  (suppress)
    );

    upd_credit_counter u_credit (
        .clk        (clk),
        .rst_n      (rst_n),
        .credit_ret (upd_credit),
        .consume    (consume),
        .credit_ok  (credit_ok)
    );

endmodule

// File: source/branch_eval.sv
`timescale 1ns/100ps
`include "br_params.svh"

module branch_eval (
    input  br_pkg::br_slot_t slot,
    output logic             taken,
    output br_pkg::pc_t      target
);

    br_pkg::word_t base;            // target base, pc or rj
    logic          eq;              // rj == rd
    logic          lt_s;            // rj < rd signed
    logic          lt_u;            // rj < rd unsigned
    logic          is_jirl;

    assign eq      = (slot.rj == slot.rd);
    assign lt_s    = ($signed(slot.rj) < $signed(slot.rd));
    assign lt_u    = (slot.rj < slot.rd);
    assign is_jirl = (slot.br_type == `BR_JIRL);

    // direction from the branch code
    always_comb begin
        case (slot.br_type)
            `BR_BEQ:  taken = eq;
            `BR_BNE:  taken = ~eq;
            `BR_BLT:  taken = lt_s;
            `BR_BGE:  taken = ~lt_s;
            `BR_BLTU: taken = lt_u;
            `BR_BGEU: taken = ~lt_u;
            `BR_B,
            `BR_BL,
            `BR_JIRL: taken = 1'b1;     // always jump
            default:  taken = 1'b0;     // none or unknown code
        endcase
    end

    // only jirl is register based, everything else pc relative
    assign base   = is_jirl ? slot.rj : slot.pc;
    assign target = base + slot.imm;    // wraps, no overflow check

endmodule

// File: source/stall_guard_fsm.sv
`timescale 1ns/100ps

module stall_guard_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic raw_br,        // unguarded redirect request
    input  logic stall_mem,
    input  logic stall_div,
    output logic suppress
);

    br_pkg::guard_state_t state;
    br_pkg::guard_state_t state_nxt;
    logic                 stall;

    assign stall = stall_mem | stall_div;

    // branch stays in execute while stalled, block the repeats
    always_comb begin
        state_nxt = state;
        case (state)
            br_pkg::IDLE: begin
                if (raw_br && stall) begin
                    state_nxt = br_pkg::HOLD;    // first redirect already out
                end
            end
            br_pkg::HOLD: begin
                if (!stall) begin
                    state_nxt = br_pkg::RELEASE; // same branch still in ex
                end
            end
            br_pkg::RELEASE: begin
                state_nxt = br_pkg::IDLE;        // one cycle only
            end
            default: begin
                state_nxt = br_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= br_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign suppress = (state != br_pkg::IDLE);   // hold and release

endmodule

// File: source/upd_credit_counter.sv
`timescale 1ns/100ps
`include "br_params.svh"

module upd_credit_counter (
    input  logic clk,
    input  logic rst_n,
    input  logic credit_ret,        // one credit back from the predictor
    input  logic consume,           // one update sent
    output logic credit_ok
);

    logic [`CREDIT_W-1:0] credit_cnt;
    logic                 inc;
    logic                 dec;

    // saturate at full, stray returns are ignored
    assign inc = credit_ret & (credit_cnt < `CREDIT_W'(`UPD_CREDITS));
    assign dec = consume & (credit_cnt != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credit_cnt <= `CREDIT_W'(`UPD_CREDITS);  // start full
        end else begin
            case ({inc, dec})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;  // both or neither
            endcase
        end
    end

    assign credit_ok = (credit_cnt != '0);

endmodule
